// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - source/rv_isa_pkg.sv
  - source/ex_pkg.sv
  - source/ex_op_if.sv
  - source/ex_decode.sv
  - source/ex_alu.sv
  - source/ex_branch.sv
  - source/ex_result_reg.sv
  - source/ex_stage.sv
  - target: test
    files:
      - sim/tb_ex_stage.sv

// ==== sim/ex_tests.txt ====
# inputs:   inst pc rs1 rs2 reg_w_en reg_w_addr (all hex)
# expected: reg_w_data mem_r_en mem_w_en mem_addr mem_w_data jump_flag jump_addr
00110093 00000000 7fffffff 00000000 1 01 80000000 0 0 00000000 00000000 0 00000000
fff12093 00000000 80000000 00000000 1 01 00000001 0 0 00000000 00000000 0 00000000
fff13093 00000000 ffffffff 00000000 1 01 00000000 0 0 00000000 00000000 0 00000000
0f014093 00000000 12345678 00000000 1 01 12345688 0 0 00000000 00000000 0 00000000
80016093 00000000 00000012 00000000 1 01 fffff812 0 0 00000000 00000000 0 00000000
0ff17093 00000000 12345678 00000000 1 01 00000078 0 0 00000000 00000000 0 00000000
01f11093 00000000 00000003 00000000 1 01 80000000 0 0 00000000 00000000 0 00000000
00115093 00000000 80000000 00000000 1 01 40000000 0 0 00000000 00000000 0 00000000
41f15093 00000000 80000000 00000000 1 01 ffffffff 0 0 00000000 00000000 0 00000000
40015093 00000000 80000001 00000000 1 01 80000001 0 0 00000000 00000000 0 00000000
003100b3 00000000 ffffffff 00000002 1 01 00000001 0 0 00000000 00000000 0 00000000
403100b3 00000000 00000000 00000001 1 01 ffffffff 0 0 00000000 00000000 0 00000000
003120b3 00000000 fffffffe 00000001 1 01 00000001 0 0 00000000 00000000 0 00000000
003130b3 00000000 00000001 fffffffe 1 01 00000001 0 0 00000000 00000000 0 00000000
003140b3 00000000 ff00ff00 0ff00ff0 1 01 f0f0f0f0 0 0 00000000 00000000 0 00000000
003160b3 00000000 ff00ff00 0ff00ff0 1 01 fff0fff0 0 0 00000000 00000000 0 00000000
003170b3 00000000 ff00ff00 0ff00ff0 1 01 0f000f00 0 0 00000000 00000000 0 00000000
003110b3 00000000 00000001 00000021 1 01 00000002 0 0 00000000 00000000 0 00000000
003150b3 00000000 80000000 0000001f 1 01 00000001 0 0 00000000 00000000 0 00000000
403150b3 00000000 80000000 00000001 1 01 c0000000 0 0 00000000 00000000 0 00000000
00310863 00001000 00000005 00000005 0 00 00000000 0 0 00000000 00000000 1 00001010
00310863 00001000 00000005 00000006 0 00 00000000 0 0 00000000 00000000 0 00001010
fe311ce3 00001000 00000005 00000006 0 00 00000000 0 0 00000000 00000000 1 00000ff8
fe311ce3 00001000 00000007 00000007 0 00 00000000 0 0 00000000 00000000 0 00000ff8
00314863 00001000 80000000 7fffffff 0 00 00000000 0 0 00000000 00000000 1 00001010
00314863 00001000 7fffffff 80000000 0 00 00000000 0 0 00000000 00000000 0 00001010
fe315ce3 00001000 ffffffff ffffffff 0 00 00000000 0 0 00000000 00000000 1 00000ff8
fe315ce3 00001000 fffffffe ffffffff 0 00 00000000 0 0 00000000 00000000 0 00000ff8
00316863 00001000 7fffffff 80000000 0 00 00000000 0 0 00000000 00000000 1 00001010
00316863 00001000 80000000 7fffffff 0 00 00000000 0 0 00000000 00000000 0 00001010
fe317ce3 00001000 80000000 7fffffff 0 00 00000000 0 0 00000000 00000000 1 00000ff8
fe317ce3 00001000 00000000 ffffffff 0 00 00000000 0 0 00000000 00000000 0 00000ff8
100000ef 00002000 00000000 00000000 1 01 00002004 0 0 00000000 00000000 1 00002100
ffc100e7 00002000 00003000 00000000 1 01 00002004 0 0 00000000 00000000 1 00002ffc
123450b7 00002000 00000000 00000000 1 01 12345000 0 0 00000000 00000000 0 00000000
fffff097 00002000 00000000 00000000 1 01 00001000 0 0 00000000 00000000 0 00000000
00812083 00002000 00001000 00000000 1 01 00000000 1 0 00001008 00000000 0 00000000
fe312e23 00002000 00001000 deadbeef 0 00 00000000 0 1 00000ffc deadbeef 0 00000000
ffffffff 00002000 12345678 87654321 0 00 00000000 0 0 00000000 00000000 0 00000000

// ==== sim/tb_ex_stage.sv ====
module tb_ex_stage import rv_isa_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    RESET_CYCLES = 3;
    localparam int    MAX_VECTORS  = 256;
    localparam string TEST_FILE    = "sim/ex_tests.txt";

    typedef struct packed {
        inst_t     inst;
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        logic      w_en;
        reg_addr_t w_addr;
        word_t     w_data;      // expected values from here on
        logic      r_en_mem;
        logic      w_en_mem;
        word_t     addr;
        word_t     w_data_mem;
        logic      jump;
        word_t     jump_addr;
    } vector_t;

    logic      clk;
    logic      rst_i;
    inst_t     inst_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    logic      reg_w_en_i;
    reg_addr_t reg_w_addr_i;
    logic      reg_w_en_o;
    reg_addr_t reg_w_addr_o;
    word_t     reg_w_data_o;
    logic      mem_r_en_o;
    logic      mem_w_en_o;
    word_t     mem_addr_o;
    word_t     mem_w_data_o;
    funct3_t   mem_funct3_o;
    logic      jump_flag_o;
    word_t     jump_addr_o;

    vector_t   vectors[$];

    ex_stage u_ex_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .reg_w_en_i   (reg_w_en_i),
        .reg_w_addr_i (reg_w_addr_i),
        .reg_w_en_o   (reg_w_en_o),
        .reg_w_addr_o (reg_w_addr_o),
        .reg_w_data_o (reg_w_data_o),
        .mem_r_en_o   (mem_r_en_o),
        .mem_w_en_o   (mem_w_en_o),
        .mem_addr_o   (mem_addr_o),
        .mem_w_data_o (mem_w_data_o),
        .mem_funct3_o (mem_funct3_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "test aborted");
    endtask

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("MISMATCH at time %0t: %s expected %h, actual %h",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        vector_t     v;
        logic [31:0] field [13];
        fd = $fopen(TEST_FILE, "r");
        assert (fd != 0) else stop_on_error({"cannot open the test file ", TEST_FILE});
        while (!$feof(fd) && vectors.size() < MAX_VECTORS) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin  // skip blank and comment lines
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            field[0], field[1], field[2], field[3], field[4], field[5],
                            field[6], field[7], field[8], field[9], field[10], field[11],
                            field[12]);
                assert (n == 13) else stop_on_error({"malformed line in test file: ", line});
                v.inst       = field[0];
                v.pc         = field[1];
                v.rs1        = field[2];
                v.rs2        = field[3];
                v.w_en       = field[4][0];
                v.w_addr     = field[5][REG_ADDR_W-1:0];
                v.w_data     = field[6];
                v.r_en_mem   = field[7][0];
                v.w_en_mem   = field[8][0];
                v.addr       = field[9];
                v.w_data_mem = field[10];
                v.jump       = field[11][0];
                v.jump_addr  = field[12];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // inputs that would set every output if reset let them through
    function automatic vector_t reset_stimulus(input int step);
        vector_t v;
        v        = '0;
        v.pc     = 32'h0000_4000;
        v.rs1    = 32'h0000_1000;
        v.rs2    = 32'hdead_beef;
        v.w_en   = 1'b1;
        v.w_addr = '1;
        case (step)
            0:       v.inst = 32'h0081_2083;  // lw x1, 8(x2)
            1:       v.inst = 32'hfe31_2e23;  // sw x3, -4(x2)
            default: v.inst = 32'h1000_00ef;  // jal x1, +0x100
        endcase
        return v;
    endfunction

    task automatic drive_inputs(input vector_t v);
        inst_i       = v.inst;
        pc_i         = v.pc;
        rs1_data_i   = v.rs1;
        rs2_data_i   = v.rs2;
        reg_w_en_i   = v.w_en;
        reg_w_addr_i = v.w_addr;
    endtask

    // write enable, address and funct3 pass straight through the register
    task automatic compare_outputs(input vector_t v);
        expect_value("reg_w_en_o", v.w_en, reg_w_en_o);
        expect_value("reg_w_addr_o", v.w_addr, reg_w_addr_o);
        expect_value("reg_w_data_o", v.w_data, reg_w_data_o);
        expect_value("mem_r_en_o", v.r_en_mem, mem_r_en_o);
        expect_value("mem_w_en_o", v.w_en_mem, mem_w_en_o);
        expect_value("mem_addr_o", v.addr, mem_addr_o);
        expect_value("mem_w_data_o", v.w_data_mem, mem_w_data_o);
        expect_value("mem_funct3_o", v.inst[14:12], mem_funct3_o);
        expect_value("jump_flag_o", v.jump, jump_flag_o);
        expect_value("jump_addr_o", v.jump_addr, jump_addr_o);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        vector_t idle;
        int      cycles;
        idle  = '0;
        rst_i = 1'b1;
        load_vectors();
        cycles = 0;
        while (cycles < RESET_CYCLES) begin
            drive_inputs(reset_stimulus(cycles));
            @(posedge clk);
            #DRIVE_DELAY;
            compare_outputs(idle);  // rst_i still high here
            cycles++;
        end
        rst_i = 1'b0;
        foreach (vectors[k]) begin
            drive_inputs(vectors[k]);
            @(posedge clk);
            #DRIVE_DELAY;
            compare_outputs(vectors[k]);  // next vector goes in right after
        end
        if (vectors.size() == 0) begin
            stop_on_error({"the test file holds no vectors: ", TEST_FILE});
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== source/ex_alu.sv ====
module ex_alu import rv_isa_pkg::*; import ex_pkg::*; (
    ex_op_if.alu  ops,
    output word_t result_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = ops.op_b[SHAMT_W-1:0];
    assign lt_s  = $signed(ops.op_a) < $signed(ops.op_b);
    assign lt_u  = ops.op_a < ops.op_b;

    always_comb begin
        case (ops.alu_op)
            ALU_ADD: begin
                result_o = ops.op_a + ops.op_b;  // wraps on overflow
            end
            ALU_SUB: begin
                result_o = ops.op_a - ops.op_b;
            end
            ALU_SLL: begin
                result_o = ops.op_a << shamt;
            end
            ALU_SLT: begin
                result_o = word_t'(lt_s);
            end
            ALU_SLTU: begin
                result_o = word_t'(lt_u);
            end
            ALU_XOR: begin
                result_o = ops.op_a ^ ops.op_b;
            end
            ALU_SRL: begin
                result_o = ops.op_a >> shamt;
            end
            ALU_SRA: begin
                result_o = word_t'($signed(ops.op_a) >>> shamt);  // sign fill
            end
            ALU_OR: begin
                result_o = ops.op_a | ops.op_b;
            end
            ALU_AND: begin
                result_o = ops.op_a & ops.op_b;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== source/ex_branch.sv ====
module ex_branch import rv_isa_pkg::*; import ex_pkg::*; (
    ex_op_if.branch ops,
    output logic    taken_o,
    output word_t   target_o
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  cond;
    word_t target_sum;

    assign eq         = ops.op_a == ops.op_b;
    assign lt_s       = $signed(ops.op_a) < $signed(ops.op_b);
    assign lt_u       = ops.op_a < ops.op_b;
    assign target_sum = ops.jump_base + ops.jump_offset;

    always_comb begin
        case (ops.br_funct)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt_s;
            BGE:     cond = !lt_s;
            BLTU:    cond = lt_u;
            BGEU:    cond = !lt_u;
            default: cond = 1'b0;  // reserved funct3
        endcase
    end

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        case (ops.cls)
            CLS_BRANCH: begin
                taken_o  = cond;
                target_o = target_sum;  // reported even when not taken
            end
            CLS_JUMP: begin
                taken_o  = 1'b1;
                target_o = target_sum;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/ex_decode.sv ====
module ex_decode import rv_isa_pkg::*; import ex_pkg::*; (
    input  inst_t    inst_i,
    input  word_t    pc_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    ex_op_if.decoder ops
);

    opcode_e     opcode;
    funct3_alu_e funct3;
    logic        alt;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_j;
    word_t       imm_u;

    function automatic alu_op_e alu_op_of(funct3_alu_e f3, logic alt_sel);
        case (f3)
            ADD_SUB: return alt_sel ? ALU_SUB : ALU_ADD;
            SLL:     return ALU_SLL;
            SLT:     return ALU_SLT;
            SLTU:    return ALU_SLTU;
            XOR:     return ALU_XOR;
            SR:      return alt_sel ? ALU_SRA : ALU_SRL;
            OR:      return ALU_OR;
            AND:     return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = funct3_alu_e'(inst_i[14:12]);
    assign alt    = inst_i[ALT_BIT];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        ops.op_a        = '0;
        ops.op_b        = '0;
        ops.alu_op      = ALU_ADD;
        ops.cls         = CLS_NONE;
        ops.br_funct    = BEQ;
        ops.jump_base   = '0;
        ops.jump_offset = '0;
        ops.store_data  = rs2_data_i;  // only used for stores
        case (opcode)
            OP_IMM: begin
                ops.cls    = CLS_ALU;
                ops.op_a   = rs1_data_i;
                ops.op_b   = imm_i;  // low 5 bits double as shamt
                ops.alu_op = alu_op_of(funct3, alt && (funct3 == SR));  // no subi
            end
            OP: begin
                ops.cls    = CLS_ALU;
                ops.op_a   = rs1_data_i;
                ops.op_b   = rs2_data_i;
                ops.alu_op = alu_op_of(funct3, alt);
            end
            LOAD: begin
                ops.cls  = CLS_LOAD;
                ops.op_a = rs1_data_i;
                ops.op_b = imm_i;
            end
            STORE: begin
                ops.cls  = CLS_STORE;
                ops.op_a = rs1_data_i;
                ops.op_b = imm_s;
            end
            BRANCH: begin
                ops.cls         = CLS_BRANCH;
                ops.op_a        = rs1_data_i;  // compared in the branch unit
                ops.op_b        = rs2_data_i;
                ops.br_funct    = funct3_br_e'(inst_i[14:12]);
                ops.jump_base   = pc_i;
                ops.jump_offset = imm_b;
            end
            JAL: begin
                ops.cls         = CLS_JUMP;
                ops.op_a        = pc_i;  // link address
                ops.op_b        = 32'd4;
                ops.jump_base   = pc_i;
                ops.jump_offset = imm_j;
            end
            JALR: begin
                ops.cls         = CLS_JUMP;
                ops.op_a        = pc_i;
                ops.op_b        = 32'd4;
                ops.jump_base   = rs1_data_i;
                ops.jump_offset = imm_i;
            end
            LUI: begin
                ops.cls  = CLS_ALU;
                ops.op_a = imm_u;
            end
            AUIPC: begin
                ops.cls  = CLS_ALU;
                ops.op_a = pc_i;
                ops.op_b = imm_u;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/ex_op_if.sv ====
interface ex_op_if import rv_isa_pkg::*; import ex_pkg::*; ();

    word_t       op_a;
    word_t       op_b;
    alu_op_e     alu_op;
    inst_class_e cls;
    funct3_br_e  br_funct;
    word_t       jump_base;
    word_t       jump_offset;
    word_t       store_data;

    modport decoder (
        output op_a, op_b, alu_op, cls, br_funct, jump_base, jump_offset, store_data
    );

    modport alu (
        input op_a, op_b, alu_op
    );

    modport branch (
        input op_a, op_b, cls, br_funct, jump_base, jump_offset
    );

    modport result (
        input cls, store_data
    );

endinterface

// ==== source/ex_pkg.sv ====
package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // what the memory and writeback stages do with the result
    typedef enum logic [2:0] {
        CLS_NONE,    // unknown opcode
        CLS_ALU,     // alu ops, lui, auipc
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP     // jal, jalr
    } inst_class_e;

endpackage

// ==== source/ex_result_reg.sv ====
module ex_result_reg import rv_isa_pkg::*; import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    ex_op_if.result   ops,
    input  word_t     alu_result_i,
    input  logic      taken_i,
    input  word_t     target_i,
    input  logic      reg_w_en_i,
    input  reg_addr_t reg_w_addr_i,
    input  funct3_t   funct3_i,
    output logic      reg_w_en_o,
    output reg_addr_t reg_w_addr_o,
    output word_t     reg_w_data_o,
    output logic      mem_r_en_o,
    output logic      mem_w_en_o,
    output word_t     mem_addr_o,
    output word_t     mem_w_data_o,
    output funct3_t   mem_funct3_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    logic  is_load;
    logic  is_store;
    word_t wb_data;

    assign is_load  = ops.cls == CLS_LOAD;
    assign is_store = ops.cls == CLS_STORE;

    always_comb begin
        case (ops.cls)
            CLS_ALU, CLS_JUMP: wb_data = alu_result_i;  // jumps write pc + 4
            default:           wb_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_w_en_o   <= 1'b0;
            reg_w_addr_o <= '0;
            reg_w_data_o <= '0;
            mem_r_en_o   <= 1'b0;
            mem_w_en_o   <= 1'b0;
            mem_addr_o   <= '0;
            mem_w_data_o <= '0;
            mem_funct3_o <= '0;
            jump_flag_o  <= 1'b0;
            jump_addr_o  <= '0;
        end else begin
            reg_w_en_o   <= reg_w_en_i;
            reg_w_addr_o <= reg_w_addr_i;
            reg_w_data_o <= wb_data;
            mem_r_en_o   <= is_load;
            mem_w_en_o   <= is_store;
            mem_addr_o   <= (is_load || is_store) ? alu_result_i : '0;  // rs1 + imm
            mem_w_data_o <= is_store ? ops.store_data : '0;
            mem_funct3_o <= funct3_i;  // access size for the memory stage
            jump_flag_o  <= taken_i;
            jump_addr_o  <= target_i;
        end
    end

endmodule

// ==== source/ex_stage.sv ====
module ex_stage import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  inst_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  logic      reg_w_en_i,
    input  reg_addr_t reg_w_addr_i,
    output logic      reg_w_en_o,
    output reg_addr_t reg_w_addr_o,
    output word_t     reg_w_data_o,
    output logic      mem_r_en_o,
    output logic      mem_w_en_o,
    output word_t     mem_addr_o,
    output word_t     mem_w_data_o,
    output funct3_t   mem_funct3_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    word_t alu_result;
    logic  br_taken;
    word_t br_target;

    ex_op_if ops ();

    ex_decode u_decode (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ops        (ops.decoder)
    );

    ex_alu u_alu (
        .ops      (ops.alu),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .ops      (ops.branch),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    // the only sequential part of the stage
    ex_result_reg u_result_reg (
        .clk          (clk),
        .rst_i        (rst_i),
        .ops          (ops.result),
        .alu_result_i (alu_result),
        .taken_i      (br_taken),
        .target_i     (br_target),
        .reg_w_en_i   (reg_w_en_i),
        .reg_w_addr_i (reg_w_addr_i),
        .funct3_i     (inst_i[14:12]),
        .reg_w_en_o   (reg_w_en_o),
        .reg_w_addr_o (reg_w_addr_o),
        .reg_w_data_o (reg_w_data_o),
        .mem_r_en_o   (mem_r_en_o),
        .mem_w_en_o   (mem_w_en_o),
        .mem_addr_o   (mem_addr_o),
        .mem_w_data_o (mem_w_data_o),
        .mem_funct3_o (mem_funct3_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // instruction bit that turns add into sub and srl into sra
    localparam int ALT_BIT    = 30;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;
    typedef logic [2:0]            funct3_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,  // register-immediate alu
        OP     = 7'b0110011,  // register-register alu
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SR      = 3'b101,  // srl or sra
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_alu_e;

    // 010 and 011 are not used by branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } funct3_br_e;

endpackage

// ==== src.f ====
source/rv_isa_pkg.sv
source/ex_pkg.sv
source/ex_op_if.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_result_reg.sv
source/ex_stage.sv
sim/tb_ex_stage.sv
